//--- common/alu_pkg.sv
package alu_pkg;

	// Opcode set of the SM83-style ALU
	typedef enum logic [4:0] {
		ADD, ADC, SUB, SBC, CP,                 // Adder group
		AND, OR, XOR,                           // Reuse G/P terms
		CPL, SCF, CCF,                          // Accumulator and carry ops
		RLC, RRC, RL, RR, SLA, SRA, SRL, SWAP,  // Shift network
		BIT, SET, RES                           // Indexed bit ops
	} alu_op_e;

	// Unit select made in decode
	typedef enum logic [1:0] {
		ARITH,     // Lookahead adder
		LOGIC,     // G/P logic merge
		SHIFT,     // Rotate/shift/swap
		FLAGONLY   // Pass operand, flags only
	} alu_unit_e;

	// Same bit order as F[7:4]
	typedef struct packed {
		logic z;
		logic n;
		logic h;
		logic c;
	} alu_flags_t;

	typedef struct packed {
		alu_op_e    op;
		logic [7:0] a;        // Accumulator or CB target register
		logic [7:0] b;        // Operand 2
		logic [2:0] bit_idx;  // BIT/SET/RES index
	} alu_req_t;

	typedef struct packed {
		alu_op_e    op;
		logic [7:0] opa;      // Operand 1, SET/RES mask applied
		logic [7:0] opb;      // Operand 2, inverted on subtract
		logic       sub;
		logic       use_cin;  // Carry flag feeds carry-in
		alu_unit_e  unit;
		logic [2:0] bit_idx;
	} alu_dec_t;

	typedef struct packed {
		alu_op_e    op;
		logic [7:0] res;
		logic       c8;        // Carry out of bit 7 or shifted-out bit
		logic       c4;        // Carry out of bit 3
		logic       bit_zero;  // Tested value is zero (BIT bit, CP difference)
		logic       sub;
		alu_unit_e  unit;
	} alu_exe_t;

	typedef struct packed {
		logic [7:0] res;
		alu_flags_t flags;
	} alu_res_t;

endpackage

//--- logic/alu_req_port.sv
`timescale 1ns/1ns

module alu_req_port (
	input  logic              clk,
	input  logic              rst,
	input  logic              req,
	input  alu_pkg::alu_req_t req_data,
	output logic              ack,
	output logic              cap_valid,
	output alu_pkg::alu_req_t cap_data
);

	logic take;  // New request, not yet acknowledged

	assign take = req & ~ack;

	// Four-phase state, ack doubles as the "already taken" marker
	always_ff @(posedge clk) begin
		if (rst) begin
			ack       <= 1'b0;
			cap_valid <= 1'b0;
		end else begin
			cap_valid <= take;  // One-cycle launch pulse
			if (take)
				ack <= 1'b1;
			else if (!req)
				ack <= 1'b0;  // Return to zero once req drops
		end
	end

	// Request fields are stable until ack, grab them on the capture edge
	always_ff @(posedge clk) begin
		if (take)
			cap_data <= req_data;
	end

endmodule

//--- alu/alu_decode.sv
`timescale 1ns/1ns

module alu_decode (
	input  logic              clk,
	input  logic              rst,
	input  logic              cap_valid,
	input  alu_pkg::alu_req_t cap_data,
	output logic              dec_valid,
	output alu_pkg::alu_dec_t dec_data
);

	alu_pkg::alu_dec_t dec_next;
	logic [7:0]        mask;  // One-hot from bit index

	assign mask = 8'b1 << cap_data.bit_idx;

	always_comb begin
		dec_next         = '0;
		dec_next.op      = cap_data.op;
		dec_next.bit_idx = cap_data.bit_idx;
		dec_next.sub     = (cap_data.op == alu_pkg::SUB) || (cap_data.op == alu_pkg::SBC) ||
			(cap_data.op == alu_pkg::CP);
		dec_next.use_cin = (cap_data.op == alu_pkg::ADC) || (cap_data.op == alu_pkg::SBC) ||
			(cap_data.op == alu_pkg::RL) || (cap_data.op == alu_pkg::RR);  // Through-carry ops
		dec_next.opb     = dec_next.sub ? ~cap_data.b : cap_data.b;  // B complement
		case (cap_data.op)
			alu_pkg::SET: dec_next.opa = cap_data.a | mask;   // Force indexed bit
			alu_pkg::RES: dec_next.opa = cap_data.a & ~mask;  // Clear indexed bit
			default:      dec_next.opa = cap_data.a;
		endcase
		case (cap_data.op)
			alu_pkg::ADD, alu_pkg::ADC, alu_pkg::SUB, alu_pkg::SBC, alu_pkg::CP:
				dec_next.unit = alu_pkg::ARITH;
			alu_pkg::AND, alu_pkg::OR, alu_pkg::XOR:
				dec_next.unit = alu_pkg::LOGIC;
			alu_pkg::RLC, alu_pkg::RRC, alu_pkg::RL, alu_pkg::RR, alu_pkg::SLA,
			alu_pkg::SRA, alu_pkg::SRL, alu_pkg::SWAP:
				dec_next.unit = alu_pkg::SHIFT;
			default:
				dec_next.unit = alu_pkg::FLAGONLY;  // CPL SCF CCF BIT SET RES
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			dec_valid <= 1'b0;
		else
			dec_valid <= cap_valid;
	end

	always_ff @(posedge clk) begin
		if (cap_valid)
			dec_data <= dec_next;
	end

endmodule

//--- alu/alu_shifter.sv
`timescale 1ns/1ns

module alu_shifter #(
	parameter int WIDTH = 8
) (
	input  alu_pkg::alu_op_e   op,
	input  logic [WIDTH-1:0]   din,
	input  logic               cin,   // Carry flag for RL/RR
	output logic [WIDTH-1:0]   dout,
	output logic               cout
);

	localparam int HALF = WIDTH / 2;  // SWAP boundary

	always_comb begin
		dout = din;  // Non-shift ops pass through
		cout = 1'b0;
		case (op)
			alu_pkg::RLC: begin
				dout = {din[WIDTH-2:0], din[WIDTH-1]};  // MSB wraps to LSB
				cout = din[WIDTH-1];
			end
			alu_pkg::RRC: begin
				dout = {din[0], din[WIDTH-1:1]};
				cout = din[0];
			end
			alu_pkg::RL: begin
				dout = {din[WIDTH-2:0], cin};  // Rotate through carry
				cout = din[WIDTH-1];
			end
			alu_pkg::RR: begin
				dout = {cin, din[WIDTH-1:1]};
				cout = din[0];
			end
			alu_pkg::SLA: begin
				dout = {din[WIDTH-2:0], 1'b0};
				cout = din[WIDTH-1];
			end
			alu_pkg::SRA: begin
				dout = {din[WIDTH-1], din[WIDTH-1:1]};  // Sign kept
				cout = din[0];
			end
			alu_pkg::SRL: begin
				dout = {1'b0, din[WIDTH-1:1]};
				cout = din[0];
			end
			alu_pkg::SWAP: dout = {din[HALF-1:0], din[WIDTH-1:HALF]};  // Carry stays 0
			default: ;
		endcase
	end

endmodule

//--- alu/alu_adder.sv
`timescale 1ns/1ns

module alu_adder #(
	parameter int WIDTH = 8
) (
	input  logic [WIDTH-1:0]  opa,
	input  logic [WIDTH-1:0]  opb,   // Already complemented for subtract
	input  logic              cin,
	input  alu_pkg::alu_unit_e unit,
	input  alu_pkg::alu_op_e  op,
	output logic [WIDTH-1:0]  sum,
	output logic              c4,    // Out of bit 3
	output logic              c8     // Out of bit 7
);

	localparam int NG = WIDTH / 4;  // 4-bit lookahead groups

	logic [WIDTH-1:0] g;   // Generate, also the AND result
	logic [WIDTH-1:0] p;   // Propagate, also the OR result
	logic [WIDTH-1:0] hx;  // Half sum, also the XOR result
	logic [WIDTH-1:0] c;   // Carry into each bit
	logic [NG:0]      gc;  // Carries between groups

	assign g  = opa & opb;
	assign p  = opa | opb;
	assign hx = p & ~g;
	assign gc[0] = cin;

	for (genvar gi = 0; gi < NG; gi++) begin : g_cla
		localparam int B = 4 * gi;
		logic grp_g;  // Group generate
		logic grp_p;  // Group propagate

		assign c[B]   = gc[gi];
		assign c[B+1] = g[B] | (p[B] & gc[gi]);
		assign c[B+2] = g[B+1] | (p[B+1] & g[B]) | (p[B+1] & p[B] & gc[gi]);
		assign c[B+3] = g[B+2] | (p[B+2] & g[B+1]) | (p[B+2] & p[B+1] & g[B]) |
			(p[B+2] & p[B+1] & p[B] & gc[gi]);
		assign grp_g = g[B+3] | (p[B+3] & g[B+2]) | (p[B+3] & p[B+2] & g[B+1]) |
			(p[B+3] & p[B+2] & p[B+1] & g[B]);
		assign grp_p = &p[B+3:B];
		assign gc[gi+1] = grp_g | (grp_p & gc[gi]);  // Ripples into next group
	end

	assign c4 = gc[1];
	assign c8 = gc[2];

	// Sum/logic merge
	always_comb begin
		if (unit == alu_pkg::LOGIC) begin
			case (op)
				alu_pkg::AND: sum = g;
				alu_pkg::OR:  sum = p;
				default:      sum = hx;  // XOR
			endcase
		end else begin
			sum = hx ^ c;
		end
	end

endmodule

//--- alu/alu_flags.sv
`timescale 1ns/1ns

module alu_flags #(
	parameter int WIDTH = 8
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                dec_valid,
	input  alu_pkg::alu_dec_t   dec_data,
	output logic                res_valid,
	output alu_pkg::alu_res_t   res_data,
	output alu_pkg::alu_flags_t flags
);

	alu_pkg::alu_flags_t flag_q, flag_next;  // Flag register and its update
	alu_pkg::alu_exe_t   exe_q, exe_next;
	logic                exe_valid;
	logic                cin, sh_cout, ad_c4, ad_c8, zero;
	logic [WIDTH-1:0]    sh_dout, ad_sum;

	assign flags = flag_q;
	assign cin   = dec_data.use_cin ? (flag_q.c ^ dec_data.sub) : dec_data.sub;  // Borrow is ~C

	alu_shifter #(.WIDTH(WIDTH)) u_shifter (
		.op(dec_data.op), .din(dec_data.opa), .cin(cin), .dout(sh_dout), .cout(sh_cout));

	alu_adder #(.WIDTH(WIDTH)) u_adder (
		.opa(dec_data.opa), .opb(dec_data.opb), .cin(cin), .unit(dec_data.unit),
		.op(dec_data.op), .sum(ad_sum), .c4(ad_c4), .c8(ad_c8));

	always_comb begin
		exe_next      = '0;
		exe_next.op   = dec_data.op;
		exe_next.sub  = dec_data.sub;
		exe_next.unit = dec_data.unit;
		exe_next.c4   = ad_c4;
		exe_next.c8   = (dec_data.unit == alu_pkg::SHIFT) ? sh_cout : ad_c8;
		exe_next.bit_zero = (dec_data.op == alu_pkg::BIT) ? ~dec_data.opa[dec_data.bit_idx] : ~|ad_sum;
		case (dec_data.unit)
			alu_pkg::SHIFT:    exe_next.res = sh_dout;
			alu_pkg::FLAGONLY: exe_next.res = (dec_data.op == alu_pkg::CPL) ? ~dec_data.opa : dec_data.opa;
			default:           exe_next.res = (dec_data.op == alu_pkg::CP) ? dec_data.opa : ad_sum;
		endcase
	end

	assign zero = ~|exe_q.res;

	always_comb begin
		flag_next = flag_q;  // SET/RES keep everything
		case (exe_q.unit)
			alu_pkg::ARITH: flag_next = {(exe_q.op == alu_pkg::CP) ? exe_q.bit_zero : zero,
				exe_q.sub, exe_q.c4 ^ exe_q.sub, exe_q.c8 ^ exe_q.sub};
			alu_pkg::LOGIC: flag_next = {zero, 1'b0, exe_q.op == alu_pkg::AND, 1'b0};
			alu_pkg::SHIFT: flag_next = {zero, 1'b0, 1'b0, exe_q.c8};
			default: case (exe_q.op)
				alu_pkg::CPL: flag_next = {flag_q.z, 1'b1, 1'b1, flag_q.c};
				alu_pkg::SCF: flag_next = {flag_q.z, 1'b0, 1'b0, 1'b1};
				alu_pkg::CCF: flag_next = {flag_q.z, 1'b0, 1'b0, ~flag_q.c};
				alu_pkg::BIT: flag_next = {exe_q.bit_zero, 1'b0, 1'b1, flag_q.c};
				default: ;
			endcase
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			exe_valid <= 1'b0;
			res_valid <= 1'b0;
			res_data  <= '0;
			flag_q    <= '0;
		end else begin
			exe_valid <= dec_valid;
			res_valid <= exe_valid;  // Single-cycle result pulse
			if (exe_valid) begin
				res_data.res   <= exe_q.res;
				res_data.flags <= flag_next;
				flag_q         <= flag_next;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (dec_valid)
			exe_q <= exe_next;  // Execute stage register
	end

endmodule

//--- logic/alu_top.sv
`timescale 1ns/1ns

module alu_top #(
	parameter int WIDTH = 8  // Datapath width for shifter and adder
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                req,
	input  alu_pkg::alu_req_t   req_data,
	output logic                ack,
	output logic                res_valid,
	output alu_pkg::alu_res_t   res_data,
	output alu_pkg::alu_flags_t flags
);

	logic              cap_valid;  // Launch pulse from the port
	alu_pkg::alu_req_t cap_data;
	logic              dec_valid;
	alu_pkg::alu_dec_t dec_data;

	// Four-phase input capture
	alu_req_port u_req_port (
		.clk(clk),
		.rst(rst),
		.req(req),
		.req_data(req_data),
		.ack(ack),
		.cap_valid(cap_valid),
		.cap_data(cap_data)
	);

	alu_decode u_decode (
		.clk(clk),
		.rst(rst),
		.cap_valid(cap_valid),
		.cap_data(cap_data),
		.dec_valid(dec_valid),
		.dec_data(dec_data)
	);

	// Execute and flag writeback
	alu_flags #(.WIDTH(WIDTH)) u_flags (
		.clk(clk),
		.rst(rst),
		.dec_valid(dec_valid),
		.dec_data(dec_data),
		.res_valid(res_valid),
		.res_data(res_data),
		.flags(flags)
	);

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
	parameter int PERIOD = 8  // In ns
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;  // Free-running, 50% duty
	end

endmodule

//--- dv/alu_checker.sv
`timescale 1ns/1ns

module alu_checker (
	input  logic                clk,
	input  logic                rst,
	input  logic                req,
	input  logic                ack,
	input  alu_pkg::alu_req_t   req_data,
	input  logic                res_valid,
	input  alu_pkg::alu_res_t   res_data,
	input  alu_pkg::alu_flags_t flags,
	input  logic                tbl_chk,       // Request also has a table expectation
	input  alu_pkg::alu_res_t   tbl_exp,
	input  logic                end_test,
	output logic                summary_done,
	output int                  error_total
);

	alu_pkg::alu_req_t   req_q[$];      // Captured, result still pending
	int                  due_q[$];      // Cycle on which the result is due
	logic                chk_q[$];
	alu_pkg::alu_res_t   tbl_q[$];
	alu_pkg::alu_flags_t model_flags;   // Reference flag register
	int                  cyc;
	int                  mismatches;
	int                  protocol_errs;
	logic                req_d;
	logic                ack_d;
	logic                first;         // First cycle out of reset

	assign error_total = mismatches + protocol_errs;

	// Reference model, SM83 flag rules in plain integer arithmetic
	function automatic alu_pkg::alu_res_t predict(input alu_pkg::alu_req_t d,
		input alu_pkg::alu_flags_t f);
		alu_pkg::alu_res_t o;
		int                ci;
		int                full;
		int                lo;
		logic              sc;  // Bit shifted out
		o.res   = d.a;
		o.flags = f;
		sc      = 1'b0;
		case (d.op)
			alu_pkg::ADD, alu_pkg::ADC: begin
				ci      = (d.op == alu_pkg::ADC) ? int'(f.c) : 0;
				full    = int'(d.a) + int'(d.b) + ci;
				lo      = int'(d.a[3:0]) + int'(d.b[3:0]) + ci;  // Nibble sum for H
				o.res   = full[7:0];
				o.flags = {full[7:0] == 8'h00, 1'b0, lo > 15, full > 255};
			end
			alu_pkg::SUB, alu_pkg::SBC, alu_pkg::CP: begin
				ci      = (d.op == alu_pkg::SBC) ? int'(f.c) : 0;
				full    = int'(d.a) - int'(d.b) - ci;
				lo      = int'(d.a[3:0]) - int'(d.b[3:0]) - ci;  // Negative means half borrow
				o.res   = (d.op == alu_pkg::CP) ? d.a : full[7:0];
				o.flags = {full[7:0] == 8'h00, 1'b1, lo < 0, full < 0};
			end
			alu_pkg::AND:  o = {d.a & d.b, (d.a & d.b) == 8'h00, 3'b010};
			alu_pkg::OR:   o = {d.a | d.b, (d.a | d.b) == 8'h00, 3'b000};
			alu_pkg::XOR:  o = {d.a ^ d.b, (d.a ^ d.b) == 8'h00, 3'b000};
			alu_pkg::CPL:  o = {~d.a, f.z, 2'b11, f.c};
			alu_pkg::SCF:  o.flags = {f.z, 2'b00, 1'b1};
			alu_pkg::CCF:  o.flags = {f.z, 2'b00, ~f.c};
			alu_pkg::BIT:  o.flags = {~d.a[d.bit_idx], 2'b01, f.c};
			alu_pkg::SET:  o.res = d.a | (8'h01 << d.bit_idx);  // Flags untouched
			alu_pkg::RES:  o.res = d.a & ~(8'h01 << d.bit_idx);
			alu_pkg::RLC:  {sc, o.res} = {d.a[7], d.a[6:0], d.a[7]};
			alu_pkg::RRC:  {o.res, sc} = {d.a[0], d.a[7:1], d.a[0]};
			alu_pkg::RL:   {sc, o.res} = {d.a, f.c};  // Through old carry
			alu_pkg::RR:   {o.res, sc} = {f.c, d.a};
			alu_pkg::SLA:  {sc, o.res} = {d.a, 1'b0};
			alu_pkg::SRA:  {o.res, sc} = {d.a[7], d.a};
			alu_pkg::SRL:  {o.res, sc} = {1'b0, d.a};
			alu_pkg::SWAP: {sc, o.res} = {1'b0, d.a[3:0], d.a[7:4]};
			default: ;
		endcase
		if (d.op inside {alu_pkg::RLC, alu_pkg::RRC, alu_pkg::RL, alu_pkg::RR,
			alu_pkg::SLA, alu_pkg::SRA, alu_pkg::SRL, alu_pkg::SWAP})
			o.flags = {o.res == 8'h00, 2'b00, sc};
		return o;
	endfunction

	always @(posedge clk) begin
		alu_pkg::alu_req_t d;
		alu_pkg::alu_res_t e;
		alu_pkg::alu_res_t t;
		int                due;
		logic              chk;
		if (rst) begin
			req_q.delete();
			due_q.delete();
			chk_q.delete();
			tbl_q.delete();
			model_flags   = '0;
			cyc           = 0;
			mismatches    = 0;
			protocol_errs = 0;
			req_d         = 1'b0;
			ack_d         = 1'b0;
			first         = 1'b1;
			summary_done <= 1'b0;
		end else begin
			cyc = cyc + 1;
			if (first && flags != 4'b0000) begin
				$display("Mismatch at %0t ns: flags %04b after reset, expected 0000", $time, flags);
				mismatches++;
			end
			if (ack && !ack_d && !req_d) begin  // Rise needs a pending req
				$display("Error at %0t ns: ack rose while req was low", $time);
				protocol_errs++;
			end
			if (!ack && ack_d && req_d) begin
				$display("Error at %0t ns: ack fell while req was still high", $time);
				protocol_errs++;
			end
			if (res_valid) begin
				if (req_q.size() == 0) begin
					$display("Error at %0t ns: result arrived with no request pending", $time);
					protocol_errs++;
				end else begin
					d           = req_q.pop_front();
					due         = due_q.pop_front();
					chk         = chk_q.pop_front();
					t           = tbl_q.pop_front();
					e           = predict(d, model_flags);
					model_flags = e.flags;
					if (cyc != due) begin
						$display("Mismatch at %0t ns: %s result on cycle %0d, expected cycle %0d",
							$time, d.op.name(), cyc, due);
						mismatches++;
					end
					if (res_data != e) begin
						$display("Mismatch at %0t ns: %s a=%02h b=%02h idx=%0d gave %02h/%04b, model %02h/%04b",
							$time, d.op.name(), d.a, d.b, d.bit_idx, res_data.res, res_data.flags,
							e.res, e.flags);
						mismatches++;
					end
					if (chk && res_data != t) begin
						$display("Mismatch at %0t ns: %s gave %02h/%04b, table %02h/%04b",
							$time, d.op.name(), res_data.res, res_data.flags, t.res, t.flags);
						mismatches++;
					end
					if (flags != e.flags) begin  // Flag port must follow the register
						$display("Mismatch at %0t ns: flags port %04b, expected %04b",
							$time, flags, e.flags);
						mismatches++;
					end
				end
			end
			if (req && !ack) begin  // Capture edge of the DUT
				req_q.push_back(req_data);
				due_q.push_back(cyc + 4);  // Pulse seen 4 edges after capture
				chk_q.push_back(tbl_chk);
				tbl_q.push_back(tbl_exp);
			end
			if (end_test && !summary_done) begin
				if (req_q.size() != 0) begin
					$display("Error: %0d request(s) never got a result", req_q.size());
					protocol_errs += req_q.size();
				end
				$display("Errors: %0d mismatch, %0d protocol", mismatches, protocol_errs);
				summary_done <= 1'b1;
			end
			req_d = req;
			ack_d = ack;
			first = 1'b0;
		end
	end

endmodule

//--- dv/tb_alu.sv
`timescale 1ns/1ns

module tb_alu;

	localparam int N_TBL      = 30;
	localparam int N_BIT      = 24;  // BIT, SET and RES at each of the 8 indices
	localparam int N_RAND     = 200;
	localparam int N_REQ      = N_TBL + N_BIT + N_RAND;
	localparam int TIMEOUT_NS = N_REQ * 12 * 8 + 50 * 8;  // 12 cycles per request

	typedef struct packed {
		alu_pkg::alu_op_e op;
		logic [7:0]       a;
		logic [7:0]       b;
		logic [2:0]       idx;
		logic [7:0]       res;   // Expected result
		logic [3:0]       znhc;  // Expected flags
	} vec_t;

	logic                clk;
	logic                rst;
	logic                req;
	alu_pkg::alu_req_t   req_data;
	logic                ack;
	logic                res_valid;
	alu_pkg::alu_res_t   res_data;
	alu_pkg::alu_flags_t flags;
	logic                tbl_chk;
	alu_pkg::alu_res_t   tbl_exp;
	logic                end_test;
	logic                summary_done;
	int                  error_total;
	int                  n_res;  // Result pulses so far
	logic [31:0]         rng;
	vec_t                tbl [N_TBL];

	tb_clk_gen #(.PERIOD(8)) u_clk_gen (.clk(clk));

	alu_top #(.WIDTH(8)) u_alu_top (
		.clk(clk),
		.rst(rst),
		.req(req),
		.req_data(req_data),
		.ack(ack),
		.res_valid(res_valid),
		.res_data(res_data),
		.flags(flags)
	);

	alu_checker u_checker (
		.clk(clk), .rst(rst), .req(req), .ack(ack), .req_data(req_data),
		.res_valid(res_valid), .res_data(res_data), .flags(flags),
		.tbl_chk(tbl_chk), .tbl_exp(tbl_exp), .end_test(end_test),
		.summary_done(summary_done), .error_total(error_total)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	// Flags chain from one row to the next, order matters
	task automatic load_table();
		tbl[0]  = {alu_pkg::ADD,  8'h3a, 8'hc6, 3'd0, 8'h00, 4'b1011};  // Carry out of 3 and 7
		tbl[1]  = {alu_pkg::ADC,  8'h01, 8'h01, 3'd0, 8'h03, 4'b0000};
		tbl[2]  = {alu_pkg::ADD,  8'h0f, 8'h01, 3'd0, 8'h10, 4'b0010};
		tbl[3]  = {alu_pkg::ADD,  8'hff, 8'h01, 3'd0, 8'h00, 4'b1011};
		tbl[4]  = {alu_pkg::SBC,  8'h10, 8'h01, 3'd0, 8'h0e, 4'b0110};  // Borrow in from C
		tbl[5]  = {alu_pkg::SUB,  8'h3e, 8'h3e, 3'd0, 8'h00, 4'b1100};
		tbl[6]  = {alu_pkg::SUB,  8'h00, 8'h01, 3'd0, 8'hff, 4'b0111};
		tbl[7]  = {alu_pkg::CP,   8'h42, 8'h42, 3'd0, 8'h42, 4'b1100};  // a comes back unchanged
		tbl[8]  = {alu_pkg::CP,   8'h10, 8'h20, 3'd0, 8'h10, 4'b0101};
		tbl[9]  = {alu_pkg::SBC,  8'h00, 8'h00, 3'd0, 8'hff, 4'b0111};
		tbl[10] = {alu_pkg::AND,  8'h5a, 8'h0f, 3'd0, 8'h0a, 4'b0010};
		tbl[11] = {alu_pkg::OR,   8'h00, 8'h00, 3'd0, 8'h00, 4'b1000};
		tbl[12] = {alu_pkg::XOR,  8'hff, 8'h0f, 3'd0, 8'hf0, 4'b0000};
		tbl[13] = {alu_pkg::SCF,  8'hf0, 8'h00, 3'd0, 8'hf0, 4'b0001};
		tbl[14] = {alu_pkg::CCF,  8'h12, 8'h00, 3'd0, 8'h12, 4'b0000};
		tbl[15] = {alu_pkg::CPL,  8'h35, 8'h00, 3'd0, 8'hca, 4'b0110};
		tbl[16] = {alu_pkg::RLC,  8'h85, 8'h00, 3'd0, 8'h0b, 4'b0001};
		tbl[17] = {alu_pkg::RL,   8'h80, 8'h00, 3'd0, 8'h01, 4'b0001};  // Old C into bit 0
		tbl[18] = {alu_pkg::RR,   8'h01, 8'h00, 3'd0, 8'h80, 4'b0001};
		tbl[19] = {alu_pkg::SLA,  8'hc1, 8'h00, 3'd0, 8'h82, 4'b0001};
		tbl[20] = {alu_pkg::SRA,  8'h81, 8'h00, 3'd0, 8'hc0, 4'b0001};
		tbl[21] = {alu_pkg::SRL,  8'h01, 8'h00, 3'd0, 8'h00, 4'b1001};
		tbl[22] = {alu_pkg::RRC,  8'h02, 8'h00, 3'd0, 8'h01, 4'b0000};
		tbl[23] = {alu_pkg::SWAP, 8'h3c, 8'h00, 3'd0, 8'hc3, 4'b0000};
		tbl[24] = {alu_pkg::BIT,  8'h80, 8'h00, 3'd7, 8'h80, 4'b0010};
		tbl[25] = {alu_pkg::BIT,  8'hfb, 8'h00, 3'd2, 8'hfb, 4'b1010};
		tbl[26] = {alu_pkg::SET,  8'h00, 8'h00, 3'd5, 8'h20, 4'b1010};  // Flags kept
		tbl[27] = {alu_pkg::RES,  8'hff, 8'h00, 3'd0, 8'hfe, 4'b1010};
		tbl[28] = {alu_pkg::ADC,  8'h0e, 8'h01, 3'd0, 8'h0f, 4'b0000};
		tbl[29] = {alu_pkg::CPL,  8'hff, 8'h00, 3'd0, 8'h00, 4'b0110};  // Z kept despite zero
	endtask

	// One four-phase cycle, drives on rising edges
	task automatic send(input alu_pkg::alu_req_t d, input logic chk, input alu_pkg::alu_res_t e);
		@(posedge clk);
		while (ack)
			@(posedge clk);  // Previous ack must be low
		req_data <= d;
		tbl_chk  <= chk;
		tbl_exp  <= e;
		req      <= 1'b1;
		@(posedge clk);
		while (!ack)
			@(posedge clk);
		req <= 1'b0;
	endtask

	always @(posedge clk) begin
		if (rst)
			n_res <= 0;
		else if (res_valid)
			n_res <= n_res + 1;
	end

	initial begin
		alu_pkg::alu_req_t d;
		logic [7:0]        onehot;  // Mask of the swept index
		rst      = 1'b1;
		req      = 1'b0;
		req_data = '0;
		tbl_chk  = 1'b0;
		tbl_exp  = '0;
		end_test = 1'b0;
		rng      = 32'hcce6_e811;
		load_table();
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		repeat (6) @(posedge clk);  // Idle window, no result allowed
		for (int i = 0; i < N_TBL; i++) begin
			d.op      = tbl[i].op;
			d.a       = tbl[i].a;
			d.b       = tbl[i].b;
			d.bit_idx = tbl[i].idx;
			send(d, 1'b1, {tbl[i].res, tbl[i].znhc});
		end
		for (int i = 0; i < N_BIT; i++) begin
			d.op      = alu_pkg::alu_op_e'(int'(alu_pkg::BIT) + i % 3);  // BIT, SET, RES in turn
			d.bit_idx = 3'(i / 3);
			onehot    = 8'h01 << d.bit_idx;
			d.a       = (d.op == alu_pkg::SET) ? ~onehot : onehot;  // Wrong index shows up
			d.b       = 8'h00;
			send(d, 1'b0, '0);
		end
		for (int i = 0; i < N_RAND; i++) begin
			rng       = xorshift(rng);
			d.op      = alu_pkg::alu_op_e'(rng[4:0] % 5'd22);
			d.a       = rng[15:8];
			d.b       = rng[23:16];
			d.bit_idx = rng[26:24];
			send(d, 1'b0, '0);  // Model alone predicts these
		end
		while (n_res < N_REQ)
			@(posedge clk);
		end_test <= 1'b1;
		@(posedge clk);
		while (!summary_done)
			@(posedge clk);
		if (error_total == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: only %0d of %0d results arrived in time", n_res, N_REQ);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- filelist.f
common/alu_pkg.sv
logic/alu_req_port.sv
alu/alu_decode.sv
alu/alu_shifter.sv
alu/alu_adder.sv
alu/alu_flags.sv
logic/alu_top.sv
dv/tb_clk_gen.sv
dv/alu_checker.sv
dv/tb_alu.sv

//--- Makefile
TOP = tb_alu

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f filelist.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
